// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP      = tb_rs_ex
FILELIST = src.f

OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== alu_eu.sv ====
`timescale 1ns/10ps
`default_nettype none

// Two-stage ALU, one op per cycle, no stall
module alu_eu (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          flush_i,
    input  logic                          valid_i,
    input  rs_pkg::alu_op_e               op_i,
    input  logic [rs_pkg::XLEN-1:0]       rs1_i,
    input  logic [rs_pkg::XLEN-1:0]       rs2_i,
    input  logic [rs_pkg::RS_IDX_LEN-1:0] entry_idx_i,          // Station slot, echoed back
    output logic                          res_valid_o,          // One-cycle pulse
    output logic [rs_pkg::RS_IDX_LEN-1:0] res_entry_idx_o,
    output logic [rs_pkg::XLEN-1:0]       res_value_o,
    output logic                          res_except_raised_o,
    output rs_pkg::except_code_e          res_except_code_o
);

    // Stage one registers
    logic                          s1_valid_q;
    rs_pkg::alu_op_e               s1_op_q;
    logic [rs_pkg::XLEN-1:0]       s1_rs1_q, s1_rs2_q;
    logic [rs_pkg::RS_IDX_LEN-1:0] s1_idx_q;

    // Stage two compute
    logic [rs_pkg::XLEN-1:0]       sum, diff, alu_res;
    logic                          ovf;

    // --------------------
    // Stage valid bits
    // --------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q  <= 1'b0;
            res_valid_o <= 1'b0;
        end else if (flush_i) begin // Flushed ops never write back
            s1_valid_q  <= 1'b0;
            res_valid_o <= 1'b0;
        end else begin
            s1_valid_q  <= valid_i;
            res_valid_o <= s1_valid_q;
        end
    end

    // Operand and result registers
    always_ff @(posedge clk_i) begin
        s1_op_q             <= op_i;
        s1_rs1_q            <= rs1_i;
        s1_rs2_q            <= rs2_i;
        s1_idx_q            <= entry_idx_i;
        res_entry_idx_o     <= s1_idx_q;
        res_value_o         <= alu_res;
        res_except_raised_o <= ovf;
        res_except_code_o   <= ovf ? rs_pkg::EXC_OVERFLOW : rs_pkg::EXC_NONE;
    end

    // --------------------
    // ALU
    // --------------------
    always_comb begin
        sum  = s1_rs1_q + s1_rs2_q;
        diff = s1_rs1_q - s1_rs2_q;
        ovf  = 1'b0;
        case (s1_op_q)
            rs_pkg::ALU_ADD: begin
                alu_res = sum;
                // Same signs in, other sign out
                ovf     = (s1_rs1_q[rs_pkg::XLEN-1] == s1_rs2_q[rs_pkg::XLEN-1])
                        & (sum[rs_pkg::XLEN-1] != s1_rs1_q[rs_pkg::XLEN-1]);
            end
            rs_pkg::ALU_SUB: begin
                alu_res = diff;
                ovf     = (s1_rs1_q[rs_pkg::XLEN-1] != s1_rs2_q[rs_pkg::XLEN-1])
                        & (diff[rs_pkg::XLEN-1] != s1_rs1_q[rs_pkg::XLEN-1]);
            end
            rs_pkg::ALU_AND: alu_res = s1_rs1_q & s1_rs2_q;
            rs_pkg::ALU_OR:  alu_res = s1_rs1_q | s1_rs2_q;
            rs_pkg::ALU_XOR: alu_res = s1_rs1_q ^ s1_rs2_q;
            rs_pkg::ALU_SLL: alu_res = s1_rs1_q << s1_rs2_q[4:0];   // 5-bit shamt
            rs_pkg::ALU_SRL: alu_res = s1_rs1_q >> s1_rs2_q[4:0];
            rs_pkg::ALU_SLT: alu_res = {{(rs_pkg::XLEN-1){1'b0}},
                                        ($signed(s1_rs1_q) < $signed(s1_rs2_q))};
            default:         alu_res = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== generic_rs.sv ====
`timescale 1ns/10ps
`default_nettype none

module generic_rs (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           flush_i,             // Synchronous flush

    // Issue side
    input  logic                           issue_valid_i,
    output logic                           issue_ready_o,
    input  rs_pkg::alu_op_e                issue_op_i,
    input  logic                           issue_rs1_ready_i,
    input  logic [rs_pkg::ROB_IDX_LEN-1:0] issue_rs1_idx_i,     // Tag waited for
    input  logic [rs_pkg::XLEN-1:0]        issue_rs1_value_i,
    input  logic                           issue_rs2_ready_i,
    input  logic [rs_pkg::ROB_IDX_LEN-1:0] issue_rs2_idx_i,
    input  logic [rs_pkg::XLEN-1:0]        issue_rs2_value_i,
    input  logic [rs_pkg::ROB_IDX_LEN-1:0] issue_dest_idx_i,    // ROB slot of the result

    // Dispatch to the EU
    output logic                           eu_valid_o,
    output rs_pkg::alu_op_e                eu_op_o,
    output logic [rs_pkg::XLEN-1:0]        eu_rs1_o,
    output logic [rs_pkg::XLEN-1:0]        eu_rs2_o,
    output logic [rs_pkg::RS_IDX_LEN-1:0]  eu_entry_idx_o,      // Comes back with the result

    // Write-back from the EU
    input  logic                           res_valid_i,
    input  logic [rs_pkg::RS_IDX_LEN-1:0]  res_entry_idx_i,
    input  logic [rs_pkg::XLEN-1:0]        res_value_i,
    input  logic                           res_except_raised_i,
    input  rs_pkg::except_code_e           res_except_code_i,

    // Result to the CDB
    output logic                           cdb_valid_o,
    input  logic                           cdb_ready_i,
    output logic [rs_pkg::ROB_IDX_LEN-1:0] cdb_idx_o,
    output logic [rs_pkg::XLEN-1:0]        cdb_data_o,
    output logic                           cdb_except_raised_o,
    output rs_pkg::except_code_e           cdb_except_code_o,

    // CDB snoop
    input  logic                           cdb_bcast_valid_i,
    input  logic [rs_pkg::ROB_IDX_LEN-1:0] cdb_bcast_idx_i,
    input  logic [rs_pkg::XLEN-1:0]        cdb_bcast_data_i,
    input  logic                           cdb_bcast_except_i   // Faulty value, never captured
);

    // --------------------
    // Entry storage
    // --------------------
    // Status bits
    logic [rs_pkg::RS_DEPTH-1:0]    valid_q;    // Entry holds an instruction
    logic [rs_pkg::RS_DEPTH-1:0]    busy_q;     // Sent to the EU
    logic [rs_pkg::RS_DEPTH-1:0]    rs1_rdy_q;  // Operand 1 value present
    logic [rs_pkg::RS_DEPTH-1:0]    rs2_rdy_q;  // Operand 2 value present
    logic [rs_pkg::RS_DEPTH-1:0]    res_rdy_q;  // Result written back

    // Payload
    rs_pkg::alu_op_e                op_q       [rs_pkg::RS_DEPTH];
    logic [rs_pkg::ROB_IDX_LEN-1:0] rs1_tag_q  [rs_pkg::RS_DEPTH];
    logic [rs_pkg::XLEN-1:0]        rs1_val_q  [rs_pkg::RS_DEPTH];
    logic [rs_pkg::ROB_IDX_LEN-1:0] rs2_tag_q  [rs_pkg::RS_DEPTH];
    logic [rs_pkg::XLEN-1:0]        rs2_val_q  [rs_pkg::RS_DEPTH];
    logic [rs_pkg::ROB_IDX_LEN-1:0] dest_q     [rs_pkg::RS_DEPTH];
    logic [rs_pkg::XLEN-1:0]        res_val_q  [rs_pkg::RS_DEPTH];
    logic                           exc_q      [rs_pkg::RS_DEPTH];
    rs_pkg::except_code_e           exc_code_q [rs_pkg::RS_DEPTH];

    // Selector request lines and results
    logic [rs_pkg::RS_DEPTH-1:0]    free_lines, disp_lines, cdb_lines;
    logic [rs_pkg::RS_IDX_LEN-1:0]  new_idx, disp_idx, cdb_sel_idx;
    logic                           new_valid, disp_valid, cdb_sel_valid;

    // CDB lock while the bus stalls
    logic                           cdb_hold_q;     // Presented entry is locked
    logic [rs_pkg::RS_IDX_LEN-1:0]  cdb_hold_idx_q;
    logic [rs_pkg::RS_IDX_LEN-1:0]  cdb_cur_idx;    // Entry on the bus

    // Snoop hits per entry and operand
    logic [rs_pkg::RS_DEPTH-1:0]    snoop1_hit, snoop2_hit;

    // Control strobes
    logic                           rs_insert, rs_pop;

    // --------------------
    // Request lines
    // --------------------
    always_comb begin
        for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
            free_lines[i] = ~valid_q[i];
            // Both operands in, not yet sent
            disp_lines[i] = valid_q[i] & rs1_rdy_q[i] & rs2_rdy_q[i] & ~busy_q[i];
            cdb_lines[i]  = valid_q[i] & res_rdy_q[i];
            // Clean broadcast carrying a tag this entry still waits for
            snoop1_hit[i] = valid_q[i] & ~rs1_rdy_q[i] & cdb_bcast_valid_i
                          & ~cdb_bcast_except_i & (rs1_tag_q[i] == cdb_bcast_idx_i);
            snoop2_hit[i] = valid_q[i] & ~rs2_rdy_q[i] & cdb_bcast_valid_i
                          & ~cdb_bcast_except_i & (rs2_tag_q[i] == cdb_bcast_idx_i);
        end
    end

    // --------------------
    // Selectors
    // --------------------
    prio_enc #(.N(rs_pkg::RS_DEPTH)) u_free_sel (   // Next free slot
        .lines_i (free_lines),
        .enc_o   (new_idx),
        .valid_o (new_valid)
    );

    prio_enc #(.N(rs_pkg::RS_DEPTH)) u_disp_sel (   // Next entry to execute
        .lines_i (disp_lines),
        .enc_o   (disp_idx),
        .valid_o (disp_valid)
    );

    prio_enc #(.N(rs_pkg::RS_DEPTH)) u_cdb_sel (    // Next result to send
        .lines_i (cdb_lines),
        .enc_o   (cdb_sel_idx),
        .valid_o (cdb_sel_valid)
    );

    // Handshakes
    assign issue_ready_o = new_valid;                   // Any free slot
    assign rs_insert     = issue_valid_i & new_valid;
    assign eu_valid_o    = disp_valid;                  // EU never stalls
    assign cdb_valid_o   = cdb_sel_valid;
    assign rs_pop        = cdb_sel_valid & cdb_ready_i;

    // Locked entry wins over a newer lower-numbered result
    assign cdb_cur_idx   = cdb_hold_q ? cdb_hold_idx_q : cdb_sel_idx;

    // --------------------
    // CDB lock
    // --------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cdb_hold_q     <= 1'b0;
            cdb_hold_idx_q <= '0;
        end else if (flush_i) begin
            cdb_hold_q     <= 1'b0;
        end else begin
            cdb_hold_q     <= cdb_sel_valid & ~cdb_ready_i;  // Stalled, keep this entry
            cdb_hold_idx_q <= cdb_cur_idx;
        end
    end

    // --------------------
    // Status update
    // --------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q   <= '0;
            busy_q    <= '0;
            rs1_rdy_q <= '0;
            rs2_rdy_q <= '0;
            res_rdy_q <= '0;
        end else if (flush_i) begin // Drop everything
            valid_q   <= '0;
            busy_q    <= '0;
            rs1_rdy_q <= '0;
            rs2_rdy_q <= '0;
            res_rdy_q <= '0;
        end else begin
            if (disp_valid) busy_q[disp_idx] <= 1'b1;   // Not picked again
            if (rs_insert) begin                        // Insert and pop never hit the same slot
                valid_q[new_idx]   <= 1'b1;
                busy_q[new_idx]    <= 1'b0;
                rs1_rdy_q[new_idx] <= issue_rs1_ready_i;
                rs2_rdy_q[new_idx] <= issue_rs2_ready_i;
                res_rdy_q[new_idx] <= 1'b0;
            end
            if (rs_pop) valid_q[cdb_cur_idx] <= 1'b0;   // Freed on CDB accept
            if (res_valid_i) res_rdy_q[res_entry_idx_i] <= 1'b1;
            // Wake-up
            rs1_rdy_q <= rs1_rdy_q | snoop1_hit;
            rs2_rdy_q <= rs2_rdy_q | snoop2_hit;
            if (rs_insert) begin    // Later assignment wins for the new slot
                rs1_rdy_q[new_idx] <= issue_rs1_ready_i;
                rs2_rdy_q[new_idx] <= issue_rs2_ready_i;
            end
        end
    end

    // --------------------
    // Payload update
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rs_insert) begin
            op_q[new_idx]      <= issue_op_i;
            rs1_tag_q[new_idx] <= issue_rs1_idx_i;
            rs1_val_q[new_idx] <= issue_rs1_value_i;
            rs2_tag_q[new_idx] <= issue_rs2_idx_i;
            rs2_val_q[new_idx] <= issue_rs2_value_i;
            dest_q[new_idx]    <= issue_dest_idx_i;
        end
        if (res_valid_i) begin // Result from the EU
            res_val_q[res_entry_idx_i]  <= res_value_i;
            exc_q[res_entry_idx_i]      <= res_except_raised_i;
            exc_code_q[res_entry_idx_i] <= res_except_code_i;
        end
        for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
            if (snoop1_hit[i]) rs1_val_q[i] <= cdb_bcast_data_i; // Captured operand
            if (snoop2_hit[i]) rs2_val_q[i] <= cdb_bcast_data_i;
        end
    end

    // --------------------
    // Read ports
    // --------------------
    // To the EU
    assign eu_op_o             = op_q[disp_idx];
    assign eu_rs1_o            = rs1_val_q[disp_idx];
    assign eu_rs2_o            = rs2_val_q[disp_idx];
    assign eu_entry_idx_o      = disp_idx;

    // To the CDB, locked on one entry while the bus stalls
    assign cdb_idx_o           = dest_q[cdb_cur_idx];
    assign cdb_data_o          = res_val_q[cdb_cur_idx];
    assign cdb_except_raised_o = exc_q[cdb_cur_idx];
    assign cdb_except_code_o   = exc_code_q[cdb_cur_idx];

endmodule

`default_nettype wire

// ==== prio_enc.sv ====
`timescale 1ns/10ps
`default_nettype none

// Fixed priority encoder, line 0 wins
module prio_enc #(
    parameter int N = 4 // Number of request lines
) (
    input  logic [N-1:0]         lines_i, // Request lines
    output logic [$clog2(N)-1:0] enc_o,   // Index of lowest set line
    output logic                 valid_o  // Any line set
);

    always_comb begin
        enc_o   = '0;
        valid_o = 1'b0;
        // Scan from the top down so the lowest set line is written last
        for (int i = N - 1; i >= 0; i--) begin
            if (lines_i[i]) begin
                enc_o   = i[$clog2(N)-1:0];
                valid_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rs_ex_props.sv ====
`timescale 1ns/10ps
`default_nettype none

// Checks bound into the reservation station
module rs_ex_props (
    input logic                           clk_i,
    input logic                           rst_n_i,
    input logic                           flush_i,
    input logic                           issue_ready_o,
    input logic                           eu_valid_o,
    input logic                           cdb_valid_o,
    input logic                           cdb_ready_i,
    input logic [rs_pkg::ROB_IDX_LEN-1:0] cdb_idx_o,
    input logic [rs_pkg::XLEN-1:0]        cdb_data_o,
    input logic [rs_pkg::RS_DEPTH-1:0]    entry_valid_i   // Station valid bits
);

    // --------------------
    // Properties
    // --------------------
    // Station comes out of reset empty
    reset_quiet_a: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !eu_valid_o && !cdb_valid_o)
        else $error("Dispatch or CDB valid high right after reset");

    // Stalled CDB output holds, a flush may drop it
    cdb_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cdb_valid_o && !cdb_ready_i && !flush_i |=> $stable(cdb_idx_o) && $stable(cdb_data_o))
        else $error("CDB tag or data moved while the bus was stalled");

    free_ready_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(&entry_valid_i) |-> issue_ready_o)   // Any free slot accepts
        else $error("Issue not ready although an entry is free");

endmodule

`default_nettype wire

// ==== rs_ex_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rs_ex_top (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           flush_i,

    // Issue
    input  logic                           issue_valid_i,
    output logic                           issue_ready_o,
    input  rs_pkg::alu_op_e                issue_op_i,
    input  logic                           issue_rs1_ready_i,
    input  logic [rs_pkg::ROB_IDX_LEN-1:0] issue_rs1_idx_i,
    input  logic [rs_pkg::XLEN-1:0]        issue_rs1_value_i,
    input  logic                           issue_rs2_ready_i,
    input  logic [rs_pkg::ROB_IDX_LEN-1:0] issue_rs2_idx_i,
    input  logic [rs_pkg::XLEN-1:0]        issue_rs2_value_i,
    input  logic [rs_pkg::ROB_IDX_LEN-1:0] issue_dest_idx_i,

    // CDB out
    output logic                           cdb_valid_o,
    input  logic                           cdb_ready_i,
    output logic [rs_pkg::ROB_IDX_LEN-1:0] cdb_idx_o,
    output logic [rs_pkg::XLEN-1:0]        cdb_data_o,
    output logic                           cdb_except_raised_o,
    output rs_pkg::except_code_e           cdb_except_code_o,

    // CDB snoop
    input  logic                           cdb_bcast_valid_i,
    input  logic [rs_pkg::ROB_IDX_LEN-1:0] cdb_bcast_idx_i,
    input  logic [rs_pkg::XLEN-1:0]        cdb_bcast_data_i,
    input  logic                           cdb_bcast_except_i
);

    // --------------------
    // Station to EU
    // --------------------
    logic                          eu_valid;
    rs_pkg::alu_op_e               eu_op;
    logic [rs_pkg::XLEN-1:0]       eu_rs1, eu_rs2;
    logic [rs_pkg::RS_IDX_LEN-1:0] eu_entry_idx;

    // EU back to station
    logic                          res_valid, res_except_raised;
    logic [rs_pkg::RS_IDX_LEN-1:0] res_entry_idx;
    logic [rs_pkg::XLEN-1:0]       res_value;
    rs_pkg::except_code_e          res_except_code;

    generic_rs u_rs (
        .clk_i, .rst_n_i, .flush_i,
        .issue_valid_i, .issue_ready_o, .issue_op_i,
        .issue_rs1_ready_i, .issue_rs1_idx_i, .issue_rs1_value_i,
        .issue_rs2_ready_i, .issue_rs2_idx_i, .issue_rs2_value_i,
        .issue_dest_idx_i,
        .eu_valid_o          (eu_valid),
        .eu_op_o             (eu_op),
        .eu_rs1_o            (eu_rs1),
        .eu_rs2_o            (eu_rs2),
        .eu_entry_idx_o      (eu_entry_idx),
        .res_valid_i         (res_valid),
        .res_entry_idx_i     (res_entry_idx),
        .res_value_i         (res_value),
        .res_except_raised_i (res_except_raised),
        .res_except_code_i   (res_except_code),
        .cdb_valid_o, .cdb_ready_i, .cdb_idx_o, .cdb_data_o,
        .cdb_except_raised_o, .cdb_except_code_o,
        .cdb_bcast_valid_i, .cdb_bcast_idx_i, .cdb_bcast_data_i, .cdb_bcast_except_i
    );

    alu_eu u_eu (
        .clk_i, .rst_n_i, .flush_i,
        .valid_i             (eu_valid),
        .op_i                (eu_op),
        .rs1_i               (eu_rs1),
        .rs2_i               (eu_rs2),
        .entry_idx_i         (eu_entry_idx),
        .res_valid_o         (res_valid),
        .res_entry_idx_o     (res_entry_idx),
        .res_value_o         (res_value),
        .res_except_raised_o (res_except_raised),
        .res_except_code_o   (res_except_code)
    );

endmodule

`default_nettype wire

// ==== rs_pkg.sv ====
`default_nettype none

package rs_pkg;

    // --------------------
    // Widths and sizes
    // --------------------
    localparam int XLEN        = 32; // Data path width
    localparam int ROB_IDX_LEN = 4;  // Reorder buffer tag width
    localparam int RS_DEPTH    = 4;  // Station entries, power of two only

    // Entry index width, follows the depth
    localparam int RS_IDX_LEN  = $clog2(RS_DEPTH);

    // --------------------
    // ALU operations
    // --------------------
    // Shift amount comes from the low 5 bits of operand 2
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0, // Signed add, can overflow
        ALU_SUB = 3'd1, // Signed subtract, can overflow
        ALU_AND = 3'd2, // Bitwise and
        ALU_OR  = 3'd3, // Bitwise or
        ALU_XOR = 3'd4, // Bitwise xor
        ALU_SLL = 3'd5, // Logical shift left
        ALU_SRL = 3'd6, // Logical shift right
        ALU_SLT = 3'd7  // Signed less than, result is 1 or 0
    } alu_op_e;

    // --------------------
    // Exception codes
    // --------------------
    // Only signed add and subtract raise anything
    typedef enum logic [1:0] {
        EXC_NONE     = 2'd0, // Clean result
        EXC_OVERFLOW = 2'd1  // Signed overflow on add or sub
    } except_code_e;

endpackage

`default_nettype wire

// ==== src.f ====
rs_pkg.sv
prio_enc.sv
generic_rs.sv
alu_eu.sv
rs_ex_top.sv
rs_ex_props.sv
tb_rs_ex.sv

// ==== tb_rs_ex.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_rs_ex;

    typedef logic [rs_pkg::XLEN-1:0]        word_t;
    typedef logic [rs_pkg::ROB_IDX_LEN-1:0] tag_t;

    localparam int     NTAG    = 2 ** rs_pkg::ROB_IDX_LEN; // Scoreboard slots, one per tag
    localparam int     TIMEOUT = 200;                      // Cycles per wait
    localparam longint MAX_S   = 64'sh7fff_ffff;           // Signed 32-bit range
    localparam longint MIN_S   = -64'sh8000_0000;

    // DUT ports
    logic clk_i, rst_n_i, flush_i;
    logic issue_valid_i, issue_ready_o, issue_rs1_ready_i, issue_rs2_ready_i;
    rs_pkg::alu_op_e issue_op_i;
    tag_t issue_rs1_idx_i, issue_rs2_idx_i, issue_dest_idx_i, cdb_idx_o, cdb_bcast_idx_i;
    word_t issue_rs1_value_i, issue_rs2_value_i, cdb_data_o, cdb_bcast_data_i;
    logic cdb_valid_o, cdb_ready_i, cdb_except_raised_o;
    rs_pkg::except_code_e cdb_except_code_o;
    logic cdb_bcast_valid_i, cdb_bcast_except_i;

    // Scoreboard, indexed by destination tag
    logic            pend  [NTAG];  // In flight
    rs_pkg::alu_op_e sb_op [NTAG];
    word_t           sb_a  [NTAG], sb_b [NTAG];
    logic            sb_w1 [NTAG], sb_w2 [NTAG]; // Operand still waits for a broadcast
    tag_t            sb_t1 [NTAG], sb_t2 [NTAG];
    int pend_cnt, recv_cnt, recv0, recv_mark;

    // Bookkeeping
    int    err_cnt, check_cnt, test_cnt, fail_tests, test_err0;
    string cur_test;
    word_t lfsr_q = 32'ha566f29c;

    // Stimulus scratch for the main sequence
    word_t a, b, v;
    rs_pkg::alu_op_e op;
    logic w1, w2;
    tag_t t1, t2;

    rs_ex_top rs_ex_top_i (.*);

    bind generic_rs rs_ex_props u_props (
        .clk_i, .rst_n_i, .flush_i, .issue_ready_o, .eu_valid_o, .cdb_valid_o,
        .cdb_ready_i, .cdb_idx_o, .cdb_data_o, .entry_valid_i (valid_q)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;   // 20 ns period
    end

    // --------------------
    // Random source
    // --------------------
    function automatic word_t lfsr_next(input word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32 22 2 1
    endfunction

    task automatic rand_bits(input int n, output word_t r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r      = {r[30:0], lfsr_q[0]};  // One step per bit
        end
    endtask

    // Expected {overflow, result} from the operation rules
    function automatic logic [32:0] ref_alu(input rs_pkg::alu_op_e f, input word_t x,
                                            input word_t y);
        longint sx, sy, wide;
        word_t  r;
        logic   ovf;
        sx  = longint'($signed(x));
        sy  = longint'($signed(y));
        ovf = 1'b0;
        case (f)
            rs_pkg::ALU_ADD: begin
                wide = sx + sy;
                r    = wide[31:0];
                ovf  = (wide > MAX_S) || (wide < MIN_S); // Out of signed range
            end
            rs_pkg::ALU_SUB: begin
                wide = sx - sy;
                r    = wide[31:0];
                ovf  = (wide > MAX_S) || (wide < MIN_S);
            end
            rs_pkg::ALU_AND: r = x & y;
            rs_pkg::ALU_OR:  r = x | y;
            rs_pkg::ALU_XOR: r = x ^ y;
            rs_pkg::ALU_SLL: r = x << y[4:0];
            rs_pkg::ALU_SRL: r = x >> y[4:0];
            default:         r = {31'b0, (sx < sy)};  // SLT
        endcase
        return {ovf, r};
    endfunction

    task automatic check_val(input string name, input word_t exp, input word_t act);
        check_cnt++;
        if (exp !== act) begin
            $display("Error in %s, %s: expected %h, actual %h", cur_test, name, exp, act);
            err_cnt++;
        end
    endtask

    // --------------------
    // Drivers
    // --------------------
    task automatic issue(input rs_pkg::alu_op_e f, input tag_t tag,
                         input logic wa, input tag_t ta, input word_t x,
                         input logic wb, input tag_t tb, input word_t y);
        int cnt;
        if (pend[tag]) begin
            $display("Tag %0d issued again while still in flight", tag);
            err_cnt++;
        end
        pend[tag]  = 1'b1;
        sb_op[tag] = f;
        sb_a[tag]  = x;
        sb_b[tag]  = y;
        sb_w1[tag] = wa;
        sb_w2[tag] = wb;
        sb_t1[tag] = ta;
        sb_t2[tag] = tb;
        pend_cnt++;
        issue_valid_i     = 1'b1;
        issue_op_i        = f;
        issue_dest_idx_i  = tag;
        issue_rs1_ready_i = ~wa;
        issue_rs1_idx_i   = ta;
        issue_rs1_value_i = x;
        issue_rs2_ready_i = ~wb;
        issue_rs2_idx_i   = tb;
        issue_rs2_value_i = y;
        cnt = 0;
        @(negedge clk_i);   // Ready is settled here
        while (!issue_ready_o && cnt < TIMEOUT) begin
            @(negedge clk_i);
            cnt++;
        end
        if (!issue_ready_o) begin
            $display("Issue of tag %0d was never accepted in test %s", tag, cur_test);
            err_cnt++;
        end
        @(posedge clk_i);
        #2;
        issue_valid_i = 1'b0;
    endtask

    task automatic broadcast(input tag_t tag, input word_t data, input logic exc);
        cdb_bcast_valid_i  = 1'b1;
        cdb_bcast_idx_i    = tag;
        cdb_bcast_data_i   = data;
        cdb_bcast_except_i = exc;
        for (int t = 0; t < NTAG; t++) begin
            if (pend[t] && !exc) begin  // Faulty values wake nothing
                if (sb_w1[t] && sb_t1[t] == tag) begin
                    sb_a[t]  = data;
                    sb_w1[t] = 1'b0;
                end
                if (sb_w2[t] && sb_t2[t] == tag) begin
                    sb_b[t]  = data;
                    sb_w2[t] = 1'b0;
                end
            end
        end
        @(posedge clk_i);
        #2;
        cdb_bcast_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (pend_cnt != 0 && cnt < TIMEOUT) begin
            @(posedge clk_i);
            #2;
            cnt++;
        end
        if (pend_cnt != 0) begin
            $display("%0d results never reached the CDB in test %s", pend_cnt, cur_test);
            err_cnt++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_err0 = err_cnt;
        recv0     = recv_cnt;
    endtask

    task automatic end_test();
        test_cnt++;
        if (err_cnt == test_err0) begin
            $display("Test %-10s passed", cur_test);
        end else begin
            $display("Test %-10s failed with %0d errors", cur_test, err_cnt - test_err0);
            fail_tests++;
        end
    endtask

    // --------------------
    // CDB monitor
    // --------------------
    always @(negedge clk_i) begin : monitor
        logic [32:0] exp;
        tag_t        tag;
        if (rst_n_i && !flush_i && cdb_valid_o && cdb_ready_i) begin   // Transfer at next edge
            tag = cdb_idx_o;
            recv_cnt++;
            if (!pend[tag]) begin
                $display("CDB transfer for tag %0d that is not in flight", tag);
                err_cnt++;
            end else if (sb_w1[tag] || sb_w2[tag]) begin
                $display("Result for tag %0d came before its operands were broadcast", tag);
                err_cnt++;
            end else begin
                exp = ref_alu(sb_op[tag], sb_a[tag], sb_b[tag]);
                check_val($sformatf("tag %0d data", tag), exp[31:0], cdb_data_o);
                check_val($sformatf("tag %0d exc", tag), {31'b0, exp[32]},
                          {31'b0, cdb_except_raised_o});
                check_val($sformatf("tag %0d code", tag),
                          exp[32] ? word_t'(rs_pkg::EXC_OVERFLOW) : word_t'(rs_pkg::EXC_NONE),
                          word_t'(cdb_except_code_o));
                pend[tag] = 1'b0;
                pend_cnt--;
            end
        end
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        issue_valid_i = 1'b0;
        issue_op_i = rs_pkg::ALU_ADD;
        issue_rs1_ready_i = 1'b0;
        issue_rs2_ready_i = 1'b0;
        issue_rs1_idx_i = '0;
        issue_rs2_idx_i = '0;
        issue_dest_idx_i = '0;
        issue_rs1_value_i = '0;
        issue_rs2_value_i = '0;
        cdb_ready_i = 1'b0;
        cdb_bcast_valid_i = 1'b0;
        cdb_bcast_idx_i = '0;
        cdb_bcast_data_i = '0;
        cdb_bcast_except_i = 1'b0;
        for (int t = 0; t < NTAG; t++) pend[t] = 1'b0;
        repeat (10) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        cdb_ready_i = 1'b1;

        start_test("reset");
        @(negedge clk_i);
        check_val("reset issue_ready", 32'd1, {31'b0, issue_ready_o});
        check_val("reset cdb_valid", 32'd0, {31'b0, cdb_valid_o});
        @(posedge clk_i);
        #2;
        end_test();

        start_test("ready_ops");    // Every op twice, random operands
        for (int i = 0; i < NTAG; i++) begin
            rand_bits(32, a);
            rand_bits(32, b);
            issue(rs_pkg::alu_op_e'(i[2:0]), tag_t'(i), 1'b0, '0, a, 1'b0, '0, b);
        end
        wait_drain();
        end_test();

        start_test("overflow");
        for (int i = 0; i < NTAG; i++) begin
            a = (i < 8) ? 32'h7fff_ffff : 32'h8000_0000; // Add overflows first, sub second
            issue(rs_pkg::alu_op_e'(i[2:0]), tag_t'(i), 1'b0, '0, a, 1'b0, '0, 32'h1);
        end
        wait_drain();
        end_test();

        start_test("dependent");
        for (int k = 0; k < rs_pkg::RS_DEPTH; k++) begin
            rand_bits(3, v);
            op = rs_pkg::alu_op_e'(v[2:0]);
            rand_bits(4, v);
            w1 = v[0];
            t1 = tag_t'({1'b1, v[3:1]});    // Producers use tags 8 to 15
            rand_bits(4, v);
            w2 = v[0];
            t2 = tag_t'({1'b1, v[3:1]});
            rand_bits(32, a);
            rand_bits(32, b);
            issue(op, tag_t'(k), w1, t1, a, w2, t2, b);
        end
        for (int k = NTAG - 1; k >= NTAG / 2; k--) begin
            rand_bits(32, a);
            broadcast(tag_t'(k), a, 1'b0);
        end
        wait_drain();
        rand_bits(32, b);
        issue(rs_pkg::ALU_XOR, tag_t'(4), 1'b1, tag_t'(8), '0, 1'b0, '0, b);
        recv_mark = recv_cnt;
        broadcast(tag_t'(8), 32'hbad0_0bad, 1'b1);
        repeat (10) @(posedge clk_i);   // Window where no result may appear
        #2;
        check_val("faulty broadcast wake", word_t'(recv_mark), word_t'(recv_cnt));
        rand_bits(32, a);
        broadcast(tag_t'(8), a, 1'b0);
        wait_drain();
        end_test();

        start_test("backpress");
        cdb_ready_i = 1'b0;
        for (int k = 0; k < rs_pkg::RS_DEPTH; k++) begin
            rand_bits(3, v);
            rand_bits(32, a);
            rand_bits(32, b);
            // Slot 0 waits, so the stalled CDB shows slot 1
            issue(rs_pkg::alu_op_e'(v[2:0]), tag_t'(k), k == 0, tag_t'(8), a, 1'b0, '0, b);
        end
        @(negedge clk_i);
        check_val("full issue_ready", 32'd0, {31'b0, issue_ready_o});
        @(posedge clk_i);
        #2;
        rand_bits(32, a);
        broadcast(tag_t'(8), a, 1'b0);  // Slot 0 result lands behind the stalled one
        repeat (6) @(posedge clk_i);    // Wake, dispatch, EU and write-back
        #2;
        cdb_ready_i = 1'b1;
        wait_drain();
        check_val("drained results", rs_pkg::RS_DEPTH, word_t'(recv_cnt - recv0));
        end_test();

        start_test("flush");
        cdb_ready_i = 1'b0;             // Keep results parked in the station
        for (int k = 0; k < rs_pkg::RS_DEPTH; k++) begin
            rand_bits(32, a);
            issue(rs_pkg::ALU_ADD, tag_t'(k), k >= 2, tag_t'(9), a, 1'b0, '0, 32'h5);
        end
        flush_i = 1'b1;
        @(posedge clk_i);
        #2;
        flush_i = 1'b0;
        for (int t = 0; t < NTAG; t++) pend[t] = 1'b0;
        pend_cnt = 0;
        cdb_ready_i = 1'b1;
        broadcast(tag_t'(9), 32'h1234, 1'b0);   // Nobody is left to wake
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        check_val("flush issue_ready", 32'd1, {31'b0, issue_ready_o});
        @(posedge clk_i);
        #2;
        for (int k = 4; k < 8; k++) begin
            rand_bits(32, a);
            rand_bits(32, b);
            issue(rs_pkg::ALU_SUB, tag_t'(k), 1'b0, '0, a, 1'b0, '0, b);
        end
        wait_drain();
        end_test();

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, fail_tests, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
